/* compile.f */
common/cache_ctrl_pkg.sv
mem_port/mem_arbiter.sv
mem_port/mem_fill_seq.sv
hw/l1_miss_handler.sv
hw/cache_ctrl_top.sv
bench/tb_clk_gen.sv
bench/cache_ctrl_chk.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_top \
    -o tb_sim

./obj_dir/tb_sim

/* bench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    localparam int MEM_BEAT_CYCLES = 2;
    localparam int NUM_RANDOM      = 20;                 // requests per port in the random mix
    localparam int NUM_REQ         = 8 + 2 * NUM_RANDOM;
    localparam int TIMEOUT_CYCLES  = NUM_REQ * (4 * MEM_BEAT_CYCLES + 20) * 2;
    localparam int FILL_CYCLES     = 4 * MEM_BEAT_CYCLES;

    logic clk;
    logic rst;
    logic instr_read;
    logic data_read;
    cache_ctrl_pkg::cache_addr_t instr_addr;
    cache_ctrl_pkg::cache_addr_t data_addr;
    logic l1_instr_hit;
    logic l1_data_hit;
    logic l2_p1_hit;
    logic l2_p2_hit;
    logic instr_busy;
    logic data_busy;
    logic miss;
    logic l2_read_p1;
    logic l2_read_p2;
    logic l1_instr_write;
    logic l1_data_write;
    cache_ctrl_pkg::l2_wr_t    l2_wr_p1;
    cache_ctrl_pkg::l2_wr_t    l2_wr_p2;
    logic ram_read;
    cache_ctrl_pkg::ram_addr_t ram_addr;
    logic fill_start;

    // index 0 of the model state is the instruction port and 1 the data port
    logic        l1_tab [2][64];  // lines present in each L1
    logic        l2_tab [2][64];  // lines seen by each L2 port
    logic        pending [2];     // port is expected to need a memory fill
    int          issue_cyc [2];
    cache_ctrl_pkg::cache_addr_t req_addr [2];
    int          busy_cnt [2];
    int          write_cnt [2];
    int          l2rd_cnt [2];
    int          fill_cnt [2];
    int          fill_cyc;
    cache_ctrl_pkg::mem_owner_e fill_owner;
    int          cycle;
    logic [31:0] rng_state;
    cache_ctrl_pkg::cache_addr_t mix_addr [2][NUM_RANDOM];  // random addresses of each port
    int          mix_gap [2][NUM_RANDOM];                   // idle cycles after each of them

    tb_clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst));

    cache_ctrl_top #(.MEM_BEAT_CYCLES(MEM_BEAT_CYCLES)) dut_i (
        .clk_i(clk), .rst_i(rst),
        .instr_read_i(instr_read), .data_read_i(data_read),
        .instr_addr_i(instr_addr), .data_addr_i(data_addr),
        .l1_instr_hit_i(l1_instr_hit), .l1_data_hit_i(l1_data_hit),
        .l2_p1_hit_i(l2_p1_hit), .l2_p2_hit_i(l2_p2_hit),
        .instr_busy_o(instr_busy), .data_busy_o(data_busy), .miss_o(miss),
        .l2_read_p1_o(l2_read_p1), .l2_read_p2_o(l2_read_p2),
        .l1_instr_write_o(l1_instr_write), .l1_data_write_o(l1_data_write),
        .l2_wr_p1_o(l2_wr_p1), .l2_wr_p2_o(l2_wr_p2),
        .ram_read_o(ram_read), .ram_read_addr_o(ram_addr), .l2_fill_start_o(fill_start)
    );

    // the lookups answer straight from the tables for the address on the port
    assign l1_instr_hit = l1_tab[0][instr_addr[9:4]];
    assign l1_data_hit  = l1_tab[1][data_addr[9:4]];
    assign l2_p2_hit    = l2_tab[0][instr_addr[9:4]];  // instruction side uses L2 port 2
    assign l2_p1_hit    = l2_tab[1][data_addr[9:4]];

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // memory word address and byte enables of one beat of a line fill
    function automatic void expected_fill(input cache_ctrl_pkg::cache_addr_t addr, input int beat,
                                          output cache_ctrl_pkg::ram_addr_t exp_addr,
                                          output cache_ctrl_pkg::byte_en_t exp_be);
        cache_ctrl_pkg::cache_addr_t line;
        line     = addr & 19'h7fff0;  // 16-byte line
        exp_addr = {13'b0100_0000_0000_0, line + 19'(4 * beat)};
        exp_be   = 16'h000f << (4 * beat);
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ram_addr(input string name, input cache_ctrl_pkg::ram_addr_t exp,
                                  input cache_ctrl_pkg::ram_addr_t act);
        if (exp !== act) begin
            stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_byte_en(input string name, input cache_ctrl_pkg::byte_en_t exp,
                                 input cache_ctrl_pkg::byte_en_t act);
        if (exp !== act) begin
            stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_owner_port(input string name, input cache_ctrl_pkg::mem_owner_e exp,
                                    input cache_ctrl_pkg::mem_owner_e act);
        if (exp !== act) stop_on_error($sformatf("[ERROR] %s: expected %s, actual %s",
                                                 name, exp.name(), act.name()));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            stop_on_error($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) stop_on_error("timeout, a request never finished");
        if (l1_instr_write) l1_tab[0][instr_addr[9:4]] <= 1'b1;  // line shows up after the write
        if (l1_data_write)  l1_tab[1][data_addr[9:4]]  <= 1'b1;
        if (l2_wr_p2.we)    l2_tab[0][ram_addr[9:4]]   <= 1'b1;
        if (l2_wr_p1.we)    l2_tab[1][ram_addr[9:4]]   <= 1'b1;
    end

    // outputs are compared on the falling edge where they are stable
    always @(negedge clk) begin
        cache_ctrl_pkg::ram_addr_t  exp_addr;
        cache_ctrl_pkg::byte_en_t   exp_be;
        cache_ctrl_pkg::mem_owner_e act_owner;
        int p;
        if (!rst) begin
            busy_cnt[0]  <= busy_cnt[0] + int'(instr_busy);
            busy_cnt[1]  <= busy_cnt[1] + int'(data_busy);
            write_cnt[0] <= write_cnt[0] + int'(l1_instr_write);
            write_cnt[1] <= write_cnt[1] + int'(l1_data_write);
            l2rd_cnt[0]  <= l2rd_cnt[0] + int'(l2_read_p2);
            l2rd_cnt[1]  <= l2rd_cnt[1] + int'(l2_read_p1);
            // a port's miss rises and falls together with its L2 read
            check_count("miss level", int'(l2_read_p1 | l2_read_p2), int'(miss));
            act_owner = (l2_wr_p2.we && !l2_wr_p1.we) ? cache_ctrl_pkg::OWNER_INSTR :
                        (l2_wr_p1.we && !l2_wr_p2.we) ? cache_ctrl_pkg::OWNER_DATA :
                                                        cache_ctrl_pkg::OWNER_NONE;
            if (ram_read) begin
                if (fill_cyc == 0) begin
                    // the oldest waiting request owns the next fill and instruction wins a tie
                    if (pending[0] && (!pending[1] || issue_cyc[0] <= issue_cyc[1]))
                        fill_owner = cache_ctrl_pkg::OWNER_INSTR;
                    else if (pending[1])
                        fill_owner = cache_ctrl_pkg::OWNER_DATA;
                    else
                        stop_on_error("memory read started with no fill expected");
                end
                p = (fill_owner == cache_ctrl_pkg::OWNER_INSTR) ? 0 : 1;
                expected_fill(req_addr[p], fill_cyc / MEM_BEAT_CYCLES, exp_addr, exp_be);
                check_ram_addr("fill address", exp_addr, ram_addr);
                check_owner_port("fill owner", fill_owner, act_owner);
                check_byte_en("fill byte enables", exp_be, (p == 0) ? l2_wr_p2.be : l2_wr_p1.be);
                check_byte_en("other port byte enables", '0,
                              (p == 0) ? l2_wr_p1.be : l2_wr_p2.be);
                check_count("fill start pulse", int'(fill_cyc == 0), int'(fill_start));
                fill_cnt[p] <= fill_cnt[p] + 1;
                fill_cyc <= fill_cyc + 1;
            end else begin
                check_owner_port("idle L2 write", cache_ctrl_pkg::OWNER_NONE, act_owner);
                check_count("idle fill start", 0, int'(fill_start));
                if (fill_cyc != 0) begin
                    // back to back fills never merge
                    check_count("fill length", FILL_CYCLES, fill_cyc);
                    pending[(fill_owner == cache_ctrl_pkg::OWNER_INSTR) ? 0 : 1] <= 1'b0;
                    fill_cyc <= 0;
                end
            end
        end
    end

    task automatic run_request(input int p, input cache_ctrl_pkg::cache_addr_t addr);
        int kind;  // 0 is an L1 hit, 1 an L2 hit and 2 a memory fill
        @(posedge clk);
        kind = l1_tab[p][addr[9:4]] ? 0 : (l2_tab[p][addr[9:4]] ? 1 : 2);
        req_addr[p]  = addr;
        issue_cyc[p] = cycle;
        busy_cnt[p]  = 0;
        write_cnt[p] = 0;
        l2rd_cnt[p]  = 0;
        fill_cnt[p]  = 0;
        if (kind == 2) pending[p] = 1'b1;
        if (p == 0) begin
            instr_addr <= addr;
            instr_read <= 1'b1;
        end else begin
            data_addr <= addr;
            data_read <= 1'b1;
        end
        @(posedge clk);
        if (p == 0) instr_read <= 1'b0;  // the handler holds the request after a one-cycle pulse
        else data_read <= 1'b0;
        @(negedge clk);
        check_count("busy after request", 1, int'((p == 0) ? instr_busy : data_busy));
        while ((p == 0) ? instr_busy : data_busy) @(negedge clk);
        if (kind == 0) check_count("L1 hit busy cycles", 1, busy_cnt[p]);
        check_count("L2 read seen", int'(kind != 0), int'(l2rd_cnt[p] != 0));
        check_count("L1 write cycles", (kind == 0) ? 0 : 2, write_cnt[p]);
        check_count("fill cycles of port", (kind == 2) ? FILL_CYCLES : 0, fill_cnt[p]);
    endtask

    task automatic random_mix(input int p);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_request(p, mix_addr[p][i]);
            repeat (mix_gap[p][i]) @(posedge clk);
        end
    endtask

    initial begin
        rng_state = 32'h89c18bd6;
        cycle = 0;
        fill_cyc = 0;
        fill_owner = cache_ctrl_pkg::OWNER_NONE;
        instr_read = 1'b0;
        data_read = 1'b0;
        instr_addr = '0;
        data_addr = '0;
        for (int p = 0; p < 2; p++) begin
            pending[p] = 1'b0;
            issue_cyc[p] = 0;
            req_addr[p] = '0;
            for (int i = 0; i < 64; i++) begin
                l1_tab[p][i] = (i % 5 == 0);  // some lines start out in L1
                l2_tab[p][i] = (i % 3 == 0);  // and some more only in L2
            end
        end
        // the random mix is drawn up front so both ports see a fixed sequence
        for (int i = 0; i < NUM_RANDOM; i++) begin
            for (int p = 0; p < 2; p++) begin
                mix_addr[p][i] = cache_ctrl_pkg::cache_addr_t'(xorshift() & 32'h3ff);
                mix_gap[p][i]  = int'(xorshift() % 4);
            end
        end
        // reset and the idle cycles after it show no activity
        do begin
            @(negedge clk);
            check_count("quiet outputs", 0, int'(instr_busy | data_busy | miss | l2_read_p1
                        | l2_read_p2 | l1_instr_write | l1_data_write | (|l2_wr_p1)
                        | (|l2_wr_p2) | ram_read | (|ram_addr) | fill_start));
        end while (rst || cycle < 14);
        run_request(0, 19'h050);  // L1 hits on both ports
        run_request(1, 19'h054);
        run_request(0, 19'h034);  // L2 hits
        run_request(1, 19'h038);
        run_request(0, 19'h07c);  // memory fills
        run_request(1, 19'h078);
        fork
            run_request(0, 19'h0b8);  // both miss in the same cycle
            run_request(1, 19'h0d4);
        join
        fork
            random_mix(0);
            random_mix(1);
        join
        repeat (4) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

/* bench/cache_ctrl_chk.sv */
`timescale 1ns/1ps

module cache_ctrl_chk (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      instr_busy_o,
    input logic                      data_busy_o,
    input logic                      miss_o,
    input logic                      l2_read_p1_o,
    input logic                      l2_read_p2_o,
    input logic                      l1_instr_write_o,
    input logic                      l1_data_write_o,
    input cache_ctrl_pkg::l2_wr_t    l2_wr_p1_o,
    input cache_ctrl_pkg::l2_wr_t    l2_wr_p2_o,
    input logic                      ram_read_o,
    input cache_ctrl_pkg::ram_addr_t ram_read_addr_o,
    input logic                      l2_fill_start_o
);
    // only one port can own a fill, so the two L2 writes never meet
    a_l2_we_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(l2_wr_p1_o.we && l2_wr_p2_o.we)) else $error("both L2 ports written at once");

    a_instr_wr_len: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(l1_instr_write_o) |=> l1_instr_write_o ##1 !l1_instr_write_o)
        else $error("instruction L1 write is not two cycles long");

    a_data_wr_len: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(l1_data_write_o) |=> l1_data_write_o ##1 !l1_data_write_o)
        else $error("data L1 write is not two cycles long");

    // first cycle out of reset still shows the reset values
    a_reset_quiet: assert property (@(posedge clk_i) $fell(rst_i) |->
        !(instr_busy_o || data_busy_o || miss_o || l2_read_p1_o || l2_read_p2_o
          || l1_instr_write_o || l1_data_write_o || (|l2_wr_p1_o) || (|l2_wr_p2_o)
          || ram_read_o || (|ram_read_addr_o) || l2_fill_start_o))
        else $error("outputs not low right after reset");

endmodule

bind cache_ctrl_top cache_ctrl_chk chk_i (.*);

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // 4 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);  // reset held for ten rising edges
        rst_o <= 1'b0;
    end

endmodule

/* hw/cache_ctrl_top.sv */
`timescale 1ns/1ps

module cache_ctrl_top #(
    parameter int MEM_BEAT_CYCLES = 2  // cycles the main memory needs for one 32-bit word
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        instr_read_i,     // instruction fetch request level
    input  logic                        data_read_i,      // data load request level
    input  cache_ctrl_pkg::cache_addr_t instr_addr_i,
    input  cache_ctrl_pkg::cache_addr_t data_addr_i,
    input  logic                        l1_instr_hit_i,
    input  logic                        l1_data_hit_i,
    input  logic                        l2_p1_hit_i,      // L2 port 1 serves the data side
    input  logic                        l2_p2_hit_i,      // L2 port 2 serves the instruction side
    output logic                        instr_busy_o,
    output logic                        data_busy_o,
    output logic                        miss_o,           // any port is handling a miss
    output logic                        l2_read_p1_o,
    output logic                        l2_read_p2_o,
    output logic                        l1_instr_write_o,
    output logic                        l1_data_write_o,
    output cache_ctrl_pkg::l2_wr_t      l2_wr_p1_o,
    output cache_ctrl_pkg::l2_wr_t      l2_wr_p2_o,
    output logic                        ram_read_o,
    output cache_ctrl_pkg::ram_addr_t   ram_read_addr_o,
    output logic                        l2_fill_start_o   // first beat of a fill, for L2 replacement
);
    cache_ctrl_pkg::fill_req_t  instr_fill_req;  // instruction handler asks for a memory fill
    cache_ctrl_pkg::fill_req_t  data_fill_req;   // data handler asks for a memory fill
    cache_ctrl_pkg::mem_owner_e mem_owner;       // current grant of the memory read port
    logic instr_fill_done;
    logic data_fill_done;
    logic instr_miss;
    logic data_miss;

    assign miss_o = instr_miss | data_miss;

    // instruction side, uses L2 port 2
    l1_miss_handler instr_handler_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .read_i      (instr_read_i),
        .addr_i      (instr_addr_i),
        .l1_hit_i    (l1_instr_hit_i),
        .l2_hit_i    (l2_p2_hit_i),
        .fill_done_i (instr_fill_done),
        .busy_o      (instr_busy_o),
        .miss_o      (instr_miss),
        .l2_read_o   (l2_read_p2_o),
        .l1_write_o  (l1_instr_write_o),
        .fill_req_o  (instr_fill_req)
    );

    // data side, uses L2 port 1
    l1_miss_handler data_handler_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .read_i      (data_read_i),
        .addr_i      (data_addr_i),
        .l1_hit_i    (l1_data_hit_i),
        .l2_hit_i    (l2_p1_hit_i),
        .fill_done_i (data_fill_done),
        .busy_o      (data_busy_o),
        .miss_o      (data_miss),
        .l2_read_o   (l2_read_p1_o),
        .l1_write_o  (l1_data_write_o),
        .fill_req_o  (data_fill_req)
    );

    mem_arbiter mem_arbiter_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .instr_req_i (instr_fill_req),
        .data_req_i  (data_fill_req),
        .owner_o     (mem_owner)
    );

    mem_fill_seq #(
        .MEM_BEAT_CYCLES (MEM_BEAT_CYCLES)
    ) mem_fill_seq_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .owner_i         (mem_owner),
        .instr_req_i     (instr_fill_req),
        .data_req_i      (data_fill_req),
        .instr_done_o    (instr_fill_done),
        .data_done_o     (data_fill_done),
        .ram_read_o      (ram_read_o),
        .ram_read_addr_o (ram_read_addr_o),
        .l2_fill_start_o (l2_fill_start_o),
        .l2_wr_p1_o      (l2_wr_p1_o),
        .l2_wr_p2_o      (l2_wr_p2_o)
    );

endmodule

/* hw/l1_miss_handler.sv */
`timescale 1ns/1ps

module l1_miss_handler (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        read_i,       // request level, sampled while idle
    input  cache_ctrl_pkg::cache_addr_t addr_i,       // held by the requester until busy drops
    input  logic                        l1_hit_i,     // L1 tag compare for addr_i
    input  logic                        l2_hit_i,     // L2 tag compare, meaningful in L2_CHECK
    input  logic                        fill_done_i,  // memory fill of our line has finished
    output logic                        busy_o,
    output logic                        miss_o,
    output logic                        l2_read_o,
    output logic                        l1_write_o,   // two cycles, one per 64-bit half
    output cache_ctrl_pkg::fill_req_t   fill_req_o
);
    cache_ctrl_pkg::miss_state_e state_q;
    cache_ctrl_pkg::cache_addr_t line_addr_q;  // line being filled, kept for the whole fill
    cache_ctrl_pkg::cache_addr_t line_addr;    // lookup address with the line offset cleared
    logic busy_q;
    logic miss_q;
    logic l2_read_q;
    logic l1_write_q;
    logic fill_req_q;

    assign line_addr = {addr_i[$bits(cache_ctrl_pkg::cache_addr_t)-1:cache_ctrl_pkg::LINE_OFFSET_BITS],
                        {cache_ctrl_pkg::LINE_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= cache_ctrl_pkg::IDLE;
            busy_q     <= 1'b0;
            miss_q     <= 1'b0;
            l2_read_q  <= 1'b0;
            l1_write_q <= 1'b0;
            fill_req_q <= 1'b0;
        end else begin
            case (state_q)
                cache_ctrl_pkg::IDLE: begin
                    if (read_i) begin
                        busy_q  <= 1'b1;                 // busy from the lookup cycle on
                        state_q <= cache_ctrl_pkg::LOOKUP;
                    end
                end
                cache_ctrl_pkg::LOOKUP: begin
                    if (l1_hit_i) begin
                        busy_q  <= 1'b0;                 // plain hit, nothing else to do
                        state_q <= cache_ctrl_pkg::IDLE;
                    end else begin
                        miss_q    <= 1'b1;
                        l2_read_q <= 1'b1;               // L2 answers one cycle later
                        state_q   <= cache_ctrl_pkg::L2_WAIT;
                    end
                end
                cache_ctrl_pkg::L2_WAIT: begin
                    state_q <= cache_ctrl_pkg::L2_CHECK; // give the L2 block ram its read cycle
                end
                cache_ctrl_pkg::L2_CHECK: begin
                    if (l2_hit_i) begin
                        l1_write_q <= 1'b1;              // line is in L2, copy it up into L1
                        state_q    <= cache_ctrl_pkg::L1_WR0;
                    end else begin
                        fill_req_q  <= 1'b1;             // ask the arbiter for main memory
                        line_addr_q <= line_addr;
                        state_q     <= cache_ctrl_pkg::FILL;
                    end
                end
                cache_ctrl_pkg::FILL: begin
                    // req stays up while the arbiter lets the other port finish first
                    if (fill_done_i) begin
                        fill_req_q <= 1'b0;              // releases the grant
                        l1_write_q <= 1'b1;              // L2 now holds the line
                        state_q    <= cache_ctrl_pkg::L1_WR0;
                    end
                end
                cache_ctrl_pkg::L1_WR0: begin
                    state_q <= cache_ctrl_pkg::L1_WR1;   // L1 ram takes 64 bits per cycle
                end
                cache_ctrl_pkg::L1_WR1: begin
                    l1_write_q <= 1'b0;
                    state_q    <= cache_ctrl_pkg::SETTLE;
                end
                cache_ctrl_pkg::SETTLE: begin
                    if (l1_hit_i) begin
                        busy_q    <= 1'b0;               // the new line is visible in L1
                        miss_q    <= 1'b0;
                        l2_read_q <= 1'b0;
                        state_q   <= cache_ctrl_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= cache_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    assign busy_o     = busy_q;
    assign miss_o     = miss_q;
    assign l2_read_o  = l2_read_q;
    assign l1_write_o = l1_write_q;

    // line_addr_q is only looked at while req is high
    assign fill_req_o = '{req: fill_req_q, line_addr: line_addr_q};

endmodule

/* mem_port/mem_fill_seq.sv */
`timescale 1ns/1ps

module mem_fill_seq #(
    parameter int MEM_BEAT_CYCLES = 2  // cycles per 32-bit memory word
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  cache_ctrl_pkg::mem_owner_e  owner_i,       // grant from the arbiter
    input  cache_ctrl_pkg::fill_req_t   instr_req_i,
    input  cache_ctrl_pkg::fill_req_t   data_req_i,
    output logic                        instr_done_o,  // one-cycle pulse after the last beat
    output logic                        data_done_o,
    output logic                        ram_read_o,
    output cache_ctrl_pkg::ram_addr_t   ram_read_addr_o,
    output logic                        l2_fill_start_o,
    output cache_ctrl_pkg::l2_wr_t      l2_wr_p1_o,    // data side L2 port
    output cache_ctrl_pkg::l2_wr_t      l2_wr_p2_o     // instruction side L2 port
);
    localparam int CYC_W  = (MEM_BEAT_CYCLES > 1) ? $clog2(MEM_BEAT_CYCLES) : 1;
    localparam int BEAT_W = $clog2(cache_ctrl_pkg::BEATS_PER_LINE);

    cache_ctrl_pkg::mem_owner_e  grant_q;       // grant of the last cycle for the edge detect
    cache_ctrl_pkg::mem_owner_e  fill_owner_q;  // port the running fill belongs to
    cache_ctrl_pkg::cache_addr_t line_addr_q;
    cache_ctrl_pkg::cache_addr_t beat_addr;     // line address plus 4 bytes per beat
    cache_ctrl_pkg::byte_en_t    beat_be;
    logic [CYC_W-1:0]            cyc_q;
    logic [BEAT_W-1:0]           beat_q;
    logic active_q;
    logic done_q;
    logic start;
    logic beat_end;
    logic owner_req;

    // request level of the granted port
    assign owner_req = (owner_i == cache_ctrl_pkg::OWNER_INSTR) ? instr_req_i.req : data_req_i.req;
    assign start     = (owner_i != cache_ctrl_pkg::OWNER_NONE)
                     && (grant_q == cache_ctrl_pkg::OWNER_NONE) && owner_req;
    assign beat_end  = (cyc_q == CYC_W'(MEM_BEAT_CYCLES - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grant_q      <= cache_ctrl_pkg::OWNER_NONE;
            fill_owner_q <= cache_ctrl_pkg::OWNER_NONE;
            active_q     <= 1'b0;
            done_q       <= 1'b0;
            cyc_q        <= '0;
            beat_q       <= '0;
        end else begin
            grant_q <= owner_i;
            done_q  <= 1'b0;
            if (start) begin
                active_q     <= 1'b1;          // beat 0 begins in the next cycle
                fill_owner_q <= owner_i;
                cyc_q        <= '0;
                beat_q       <= '0;
            end else if (active_q) begin
                if (!beat_end) begin
                    cyc_q <= cyc_q + 1'b1;
                end else if (beat_q == BEAT_W'(cache_ctrl_pkg::BEATS_PER_LINE - 1)) begin
                    active_q <= 1'b0;          // whole line is in L2
                    done_q   <= 1'b1;
                end else begin
                    cyc_q  <= '0;
                    beat_q <= beat_q + 1'b1;   // next word of the line
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            line_addr_q <= (owner_i == cache_ctrl_pkg::OWNER_INSTR) ? instr_req_i.line_addr
                                                                     : data_req_i.line_addr;
        end
    end

    assign beat_addr = line_addr_q + cache_ctrl_pkg::cache_addr_t'({beat_q, 2'b00});
    assign beat_be   = cache_ctrl_pkg::byte_en_t'(cache_ctrl_pkg::BEAT_BYTE_EN) << {beat_q, 2'b00};

    assign ram_read_o      = active_q;
    assign ram_read_addr_o = active_q ? {cache_ctrl_pkg::RAM_BASE_PREFIX, beat_addr} : '0;
    assign l2_fill_start_o = active_q && (beat_q == '0) && (cyc_q == '0);

    // byte enables go only to the L2 port of the port that owns the fill
    assign l2_wr_p1_o.we = active_q && (fill_owner_q == cache_ctrl_pkg::OWNER_DATA);
    assign l2_wr_p1_o.be = l2_wr_p1_o.we ? beat_be : '0;
    assign l2_wr_p2_o.we = active_q && (fill_owner_q == cache_ctrl_pkg::OWNER_INSTR);
    assign l2_wr_p2_o.be = l2_wr_p2_o.we ? beat_be : '0;

    assign instr_done_o = done_q && (fill_owner_q == cache_ctrl_pkg::OWNER_INSTR);
    assign data_done_o  = done_q && (fill_owner_q == cache_ctrl_pkg::OWNER_DATA);

endmodule

/* mem_port/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  cache_ctrl_pkg::fill_req_t  instr_req_i,  // fill request of the instruction port
    input  cache_ctrl_pkg::fill_req_t  data_req_i,   // fill request of the data port
    output cache_ctrl_pkg::mem_owner_e owner_o       // port that may use the memory read port
);
    cache_ctrl_pkg::mem_owner_e owner_q;

    // a grant is only given out from NONE, so two fills are always separated by
    // at least one free cycle and the fill sequencer sees a clean edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            owner_q <= cache_ctrl_pkg::OWNER_NONE;
        end else begin
            case (owner_q)
                cache_ctrl_pkg::OWNER_NONE: begin
                    if (instr_req_i.req) begin
                        owner_q <= cache_ctrl_pkg::OWNER_INSTR;  // fetch wins a tie
                    end else if (data_req_i.req) begin
                        owner_q <= cache_ctrl_pkg::OWNER_DATA;
                    end
                end
                cache_ctrl_pkg::OWNER_INSTR: begin
                    if (!instr_req_i.req) begin
                        owner_q <= cache_ctrl_pkg::OWNER_NONE;  // handler released the port
                    end
                end
                cache_ctrl_pkg::OWNER_DATA: begin
                    if (!data_req_i.req) begin
                        owner_q <= cache_ctrl_pkg::OWNER_NONE;
                    end
                end
                default: begin
                    owner_q <= cache_ctrl_pkg::OWNER_NONE;
                end
            endcase
        end
    end

    assign owner_o = owner_q;

endmodule

/* common/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

    // address and mask widths that carry a meaning in the controller
    typedef logic [18:0] cache_addr_t;  // byte address seen by L1 and L2
    typedef logic [31:0] ram_addr_t;    // byte address on the main-memory read port
    typedef logic [15:0] byte_en_t;     // one enable per byte of a 16-byte L2 line

    // main memory sits in a fixed window, the cache address fills the low 19 bits
    localparam logic [12:0] RAM_BASE_PREFIX = 13'b0100_0000_0000_0;

    localparam int LINE_OFFSET_BITS = 4;        // 16-byte line
    localparam int BEATS_PER_LINE   = 4;        // four 32-bit words per line
    localparam logic [3:0] BEAT_BYTE_EN = 4'hF; // one word worth of byte enables

    // who currently owns the single main-memory read port
    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_INSTR,
        OWNER_DATA
    } mem_owner_e;

    // per-port read miss sequence
    typedef enum logic [2:0] {
        IDLE,      // waiting for a read request
        LOOKUP,    // L1 tag result is valid here
        L2_WAIT,   // L2 read was issued, its result needs a cycle
        L2_CHECK,  // L2 hit decides between an L1 refill and a memory fill
        FILL,      // waiting for the memory fill to complete
        L1_WR0,    // first half of the 128-bit L1 write
        L1_WR1,    // second half of the 128-bit L1 write
        SETTLE     // wait until L1 reports the line as present
    } miss_state_e;

    // line fill request from a miss handler
    typedef struct packed {
        logic        req;        // held high until the fill is done
        cache_addr_t line_addr;  // line aligned, low offset bits are zero
    } fill_req_t;

    // write strobe towards one L2 port
    typedef struct packed {
        logic     we;  // write enable
        byte_en_t be;  // bytes of the line written in this beat
    } l2_wr_t;

endpackage
